/* filelist.f */
+incdir+src
src/pixel_pkg.sv
src/timing_pkg.sv
src/pattern_writer.sv
src/frame_buffer.sv
src/vga_timing.sv
src/pixel_output.sv
src/vga_checker_top.sv
verification/tb_vga_checker.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the VGA checkerboard testbench with Verilator
# Exit status is the simulator's own status

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module tb_vga_checker -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit $build_status
fi

./obj_dir/Vtb_vga_checker
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "Simulation failed with status $sim_status"
fi
exit $sim_status

/* src/frame_buffer.sv */
`timescale 1ns/10ps

`include "vga_macros.svh"

module frame_buffer (
	input logic M10k_pll,
	input logic wr_en,
	input timing_pkg::fb_addr_t wr_addr,
	input pixel_pkg::pixel_t wr_pixel,
	input timing_pkg::fb_addr_t rd_addr,
	output pixel_pkg::pixel_t rd_pixel
);

	// One byte per pixel, whole frame
	logic [7:0] mem [0:`FB_DEPTH-1];

	// Write port
	always_ff @(posedge M10k_pll) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_pixel.raw;
		end
	end

	// Read port, registered
	// Same-address collision returns the old byte
	always_ff @(posedge M10k_pll) begin
		rd_pixel <= pixel_pkg::pixel_t'(mem[rd_addr]);
	end

	// Read address comes from the timing stage
	// Must never leave the frame
	a_rd_addr_range: assert property (@(posedge M10k_pll)
		!$isunknown(rd_addr) |-> rd_addr < `FB_DEPTH)
		else $error("frame_buffer: read address %0d out of range", rd_addr);

endmodule

/* src/pattern_writer.sv */
`timescale 1ns/10ps

`include "vga_macros.svh"

module pattern_writer (
	input logic M10k_pll,
	input logic reset,
	output logic wr_en,
	output timing_pkg::fb_addr_t wr_addr,
	output pixel_pkg::pixel_t wr_pixel
);

	// Raster position of the next write
	timing_pkg::coord_t x;
	timing_pkg::coord_t y;
	logic x_last;
	logic y_last;
	pixel_pkg::pixel_t quad_pixel;

	assign x_last = (x == `FRAME_W - 1);
	assign y_last = (y == `FRAME_H - 1);

	// Quadrant select, left half first
	always_comb begin
		if (x < `FRAME_W / 2) begin
			quad_pixel = (y < `FRAME_H / 2) ? pixel_pkg::color_red : pixel_pkg::color_green;
		end else begin
			quad_pixel = (y < `FRAME_H / 2) ? pixel_pkg::color_blue : pixel_pkg::color_yellow;
		end
	end

	// Raster walk, one pixel per cycle, wraps at end of frame
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			x <= '0;
			y <= '0;
			wr_en <= 1'b0;
		end else begin
			// Writes run forever once out of reset
			wr_en <= 1'b1;
			x <= x_last ? '0 : x + 1'b1;
			if (x_last) begin
				y <= y_last ? '0 : y + 1'b1;
			end
		end
	end

	// Write word for the coordinate held this cycle
	always_ff @(posedge M10k_pll) begin
		wr_addr <= timing_pkg::fb_addr_t'(y * `FRAME_W + x);
		wr_pixel <= quad_pixel;
	end

	// Address must land inside the buffer
	a_wr_addr_range: assert property (@(posedge M10k_pll) disable iff (reset)
		wr_en |-> wr_addr < `FB_DEPTH)
		else $error("pattern_writer: write address %0d out of range", wr_addr);

endmodule

/* src/pixel_output.sv */
`timescale 1ns/10ps

module pixel_output (
	input logic M10k_pll,
	input logic reset,
	input pixel_pkg::pixel_t rd_pixel,
	input logic video_active,
	input logic h_sync_early,
	input logic v_sync_early,
	output logic hsync,
	output logic vsync,
	output logic blank_n,
	output pixel_pkg::channel_t red,
	output pixel_pkg::channel_t green,
	output pixel_pkg::channel_t blue
);

	// Controls held one cycle to stay in step with the memory read
	logic active_d1;
	logic hsync_d1;
	logic vsync_d1;

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			// Syncs idle high
			active_d1 <= 1'b0;
			hsync_d1 <= 1'b1;
			vsync_d1 <= 1'b1;
			hsync <= 1'b1;
			vsync <= 1'b1;
			blank_n <= 1'b0;
			red <= '0;
			green <= '0;
			blue <= '0;
		end else begin
			active_d1 <= video_active;
			hsync_d1 <= h_sync_early;
			vsync_d1 <= v_sync_early;
			// Second delay lines up with the colour
			hsync <= hsync_d1;
			vsync <= vsync_d1;
			blank_n <= active_d1;
			// Fields go to the top bits with zero fill below
			// Black during blanking
			red <= active_d1 ? {rd_pixel.fields.red, 5'b0} : '0;
			green <= active_d1 ? {rd_pixel.fields.green, 5'b0} : '0;
			blue <= active_d1 ? {rd_pixel.fields.blue, 6'b0} : '0;
		end
	end

	// Blank and black two cycles after the scan leaves the picture
	a_black_in_blank: assert property (@(posedge M10k_pll) disable iff (reset)
		!$past(video_active, 2) |-> !blank_n && (red == '0) && (green == '0) && (blue == '0))
		else $error("pixel_output: colour during blanking");

endmodule

/* src/pixel_pkg.sv */
package pixel_pkg;

	// RGB 3-3-2, red in the top bits
	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} rgb332_t;

	// Same byte seen two ways
	// Raw on the write side and in memory, fields at the output
	typedef union packed {
		logic [7:0] raw;
		rgb332_t fields;
	} pixel_t;

	// One 8-bit DAC channel
	typedef logic [7:0] channel_t;

	////////////////////////////////////////////////////////////
	// Quadrant colours
	////////////////////////////////////////////////////////////

	// Upper left
	localparam pixel_t color_red = pixel_t'(8'b111_000_00);

	// Lower left
	localparam pixel_t color_green = pixel_t'(8'b000_111_00);

	// Upper right
	localparam pixel_t color_blue = pixel_t'(8'b000_000_11);

	// Lower right, full red plus full green
	localparam pixel_t color_yellow = pixel_t'(8'b111_111_00);

endpackage

/* src/timing_pkg.sv */
package timing_pkg;

	`include "vga_macros.svh"

	// Horizontal or vertical counter value
	typedef logic [`COORD_W-1:0] coord_t;

	// Linear buffer address, y * width + x
	typedef logic [`ADDR_W-1:0] fb_addr_t;

	// Scan phases in the order they occur
	// Shared by the line and the frame machine
	typedef enum logic [1:0] {
		active = 2'd0,
		front = 2'd1,
		pulse = 2'd2,
		back = 2'd3
	} phase_t;

endpackage

/* src/vga_checker_top.sv */
`timescale 1ns/10ps

module vga_checker_top (
	input logic M10k_pll,
	input logic reset,
	output logic hsync,
	output logic vsync,
	output logic blank_n,
	output pixel_pkg::channel_t red,
	output pixel_pkg::channel_t green,
	output pixel_pkg::channel_t blue
);

	// Writer to buffer
	logic wr_en;
	timing_pkg::fb_addr_t wr_addr;
	pixel_pkg::pixel_t wr_pixel;

	// Timing to buffer, buffer to output
	timing_pkg::fb_addr_t rd_addr;
	pixel_pkg::pixel_t rd_pixel;

	// Timing to output, undelayed
	logic video_active;
	logic h_sync_early;
	logic v_sync_early;

	////////////////////////////////////////////////////////////
	// Stages
	////////////////////////////////////////////////////////////

	// Checkerboard source
	pattern_writer u_writer (
		.M10k_pll(M10k_pll),
		.reset(reset),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_pixel(wr_pixel)
	);

	// Frame store
	frame_buffer u_buffer (
		.M10k_pll(M10k_pll),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_pixel(wr_pixel),
		.rd_addr(rd_addr),
		.rd_pixel(rd_pixel)
	);

	// 640x480 scan
	vga_timing u_timing (
		.M10k_pll(M10k_pll),
		.reset(reset),
		.rd_addr(rd_addr),
		.video_active(video_active),
		.h_sync_early(h_sync_early),
		.v_sync_early(v_sync_early)
	);

	// Colour expand and sync align
	pixel_output u_output (
		.M10k_pll(M10k_pll),
		.reset(reset),
		.rd_pixel(rd_pixel),
		.video_active(video_active),
		.h_sync_early(h_sync_early),
		.v_sync_early(v_sync_early),
		.hsync(hsync),
		.vsync(vsync),
		.blank_n(blank_n),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

/* src/vga_macros.svh */
`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

// Visible frame, in pixels and lines
`define FRAME_W 640
`define FRAME_H 480

// Horizontal blanking, in clock cycles
`define H_FRONT 16
`define H_PULSE 96
`define H_BACK 48

// Vertical blanking, in whole lines
`define V_FRONT 10
`define V_PULSE 2
`define V_BACK 33

// Counter width, covers 800 cycles and 525 lines
`define COORD_W 10

// Buffer address width and depth
`define ADDR_W 19
`define FB_DEPTH (`FRAME_W * `FRAME_H)

`endif

/* src/vga_timing.sv */
`timescale 1ns/10ps

`include "vga_macros.svh"

module vga_timing (
	input logic M10k_pll,
	input logic reset,
	output timing_pkg::fb_addr_t rd_addr,
	output logic video_active,
	output logic h_sync_early,
	output logic v_sync_early
);

	// Line machine
	timing_pkg::phase_t h_phase;
	timing_pkg::coord_t h_count;
	logic h_end;

	// Frame machine
	timing_pkg::phase_t v_phase;
	timing_pkg::coord_t v_count;
	logic v_end;

	// Last cycle of the back porch
	logic line_end;

	////////////////////////////////////////////////////////////
	// Phase tables
	////////////////////////////////////////////////////////////

	// Final count of a phase, lines when vertical, cycles otherwise
	function automatic timing_pkg::coord_t phase_last(timing_pkg::phase_t p, logic vertical);
		int len;
		case (p)
			timing_pkg::active: len = vertical ? `FRAME_H : `FRAME_W;
			timing_pkg::front: len = vertical ? `V_FRONT : `H_FRONT;
			timing_pkg::pulse: len = vertical ? `V_PULSE : `H_PULSE;
			default: len = vertical ? `V_BACK : `H_BACK;
		endcase
		return timing_pkg::coord_t'(len - 1);
	endfunction

	// Active, front, pulse, back, then around again
	function automatic timing_pkg::phase_t phase_next(timing_pkg::phase_t p);
		case (p)
			timing_pkg::active: return timing_pkg::front;
			timing_pkg::front: return timing_pkg::pulse;
			timing_pkg::pulse: return timing_pkg::back;
			default: return timing_pkg::active;
		endcase
	endfunction

	assign h_end = (h_count == phase_last(h_phase, 1'b0));
	assign v_end = (v_count == phase_last(v_phase, 1'b1));
	assign line_end = h_end && (h_phase == timing_pkg::back);

	////////////////////////////////////////////////////////////
	// Scan counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			// Start at top left of the visible frame
			h_phase <= timing_pkg::active;
			h_count <= '0;
			v_phase <= timing_pkg::active;
			v_count <= '0;
		end else begin
			// Horizontal steps every cycle
			if (h_end) begin
				h_count <= '0;
				h_phase <= phase_next(h_phase);
			end else begin
				h_count <= h_count + 1'b1;
			end
			// Vertical steps once per full line
			if (line_end) begin
				if (v_end) begin
					v_count <= '0;
					v_phase <= phase_next(v_phase);
				end else begin
					v_count <= v_count + 1'b1;
				end
			end
		end
	end

	// Levels for the current scan position
	// Output stage adds the pipeline delay
	assign video_active = (h_phase == timing_pkg::active) && (v_phase == timing_pkg::active);
	assign h_sync_early = (h_phase != timing_pkg::pulse);
	assign v_sync_early = (v_phase != timing_pkg::pulse);

	// Look-ahead read, zero outside the picture
	assign rd_addr = video_active ? timing_pkg::fb_addr_t'(v_count * `FRAME_W + h_count) : '0;

	// Counters never run past their phase
	a_count_in_phase: assert property (@(posedge M10k_pll) disable iff (reset)
		(h_count <= phase_last(h_phase, 1'b0)) && (v_count <= phase_last(v_phase, 1'b1)))
		else $error("vga_timing: counter beyond phase length");

endmodule

/* verification/tb_vga_checker.sv */
`timescale 1ns/10ps

`include "vga_macros.svh"

module tb_vga_checker;

	// Scan geometry in cycles and lines
	localparam int line_len = `FRAME_W + `H_FRONT + `H_PULSE + `H_BACK;
	localparam int frame_lines = `FRAME_H + `V_FRONT + `V_PULSE + `V_BACK;
	localparam longint frame_time = longint'(line_len) * frame_lines * 100;

	logic M10k_pll;
	logic reset;
	logic hsync;
	logic vsync;
	logic blank_n;
	pixel_pkg::channel_t red;
	pixel_pkg::channel_t green;
	pixel_pkg::channel_t blue;

	// Monitor state
	logic running;
	logic prev_hsync;
	logic prev_vsync;
	logic prev_blank;
	logic h_seen;
	int vsync_falls;
	timing_pkg::coord_t h_period;
	timing_pkg::coord_t h_low;
	timing_pkg::coord_t blank_len;
	timing_pkg::coord_t lines_in_frame;
	timing_pkg::coord_t active_lines;
	timing_pkg::coord_t sync_lines;
	int px;
	int py;
	logic line_sel [0:`FRAME_H-1];
	logic [3:0] quad_seen;
	pixel_pkg::channel_t exp_r;
	pixel_pkg::channel_t exp_g;
	pixel_pkg::channel_t exp_b;

	vga_checker_top dut (
		.M10k_pll(M10k_pll),
		.reset(reset),
		.hsync(hsync),
		.vsync(vsync),
		.blank_n(blank_n),
		.red(red),
		.green(green),
		.blue(blue)
	);

	// 100 ns clock
	initial begin
		M10k_pll = 1'b0;
		forever #50 M10k_pll = ~M10k_pll;
	end

	// Give up after four frame times
	initial begin
		#(4 * frame_time);
		$display("Timeout: the scan did not finish three frames in time");
		$display("Done: errors found");
		$fatal(1, "watchdog expired");
	end

	////////////////////////////////////////////////////////////
	// Reference model and compare tasks
	////////////////////////////////////////////////////////////

	// Counter that sticks at all ones instead of wrapping
	function automatic timing_pkg::coord_t bump(timing_pkg::coord_t c);
		return (c == '1) ? c : c + 1'b1;
	endfunction

	// 0 upper left, 1 upper right, 2 lower left, 3 lower right
	function automatic int quadrant(int x, int y);
		return ((y >= `FRAME_H / 2) ? 2 : 0) + ((x >= `FRAME_W / 2) ? 1 : 0);
	endfunction

	// Red upper left and green lower left
	// Blue upper right and yellow lower right
	// Each field sits in the top bits of its channel
	function automatic void ref_color(input int x, input int y,
		output pixel_pkg::channel_t r, output pixel_pkg::channel_t g,
		output pixel_pkg::channel_t b);
		int q;
		q = quadrant(x, y);
		r = (q == 0 || q == 3) ? 8'he0 : 8'h00;
		g = (q >= 2) ? 8'he0 : 8'h00;
		b = (q == 1) ? 8'hc0 : 8'h00;
	endfunction

	task automatic check_color(input string what, input pixel_pkg::channel_t got,
		input pixel_pkg::channel_t expected);
		if (got !== expected) begin
			$display("error %0d ns: %s is 0x%02h, expected 0x%02h (x %0d, line %0d)",
				$time, what, got, expected, px, py);
			$display("Done: errors found");
			$fatal(1, "colour mismatch");
		end
	endtask

	task automatic check_count(input string what, input timing_pkg::coord_t got,
		input timing_pkg::coord_t expected);
		if (got !== expected) begin
			$display("error %0d ns: %s is %0d, expected %0d", $time, what, got, expected);
			$display("Done: errors found");
			$fatal(1, "count mismatch");
		end
	endtask

	task automatic check_level(input string what, input logic got, input logic expected);
		if (got !== expected) begin
			$display("error %0d ns: %s is %b, expected %b", $time, what, got, expected);
			$display("Done: errors found");
			$fatal(1, "level mismatch");
		end
	endtask

	// Idle outputs have syncs high and black colour
	task automatic check_idle();
		check_level("hsync", hsync, 1'b1);
		check_level("vsync", vsync, 1'b1);
		check_level("blank_n", blank_n, 1'b0);
		check_color("red", red, 8'h00);
		check_color("green", green, 8'h00);
		check_color("blue", blue, 8'h00);
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(56691));
		reset = 1'b1;
		running = 1'b0;
		prev_hsync = 1'b1;
		prev_vsync = 1'b1;
		prev_blank = 1'b0;
		h_seen = 1'b0;
		vsync_falls = 0;
		h_period = '0;
		h_low = '0;
		blank_len = '0;
		lines_in_frame = '0;
		active_lines = '0;
		sync_lines = '0;
		px = 0;
		py = 0;
		quad_seen = '0;
		// About one line in four plus the top and bottom lines
		for (int i = 0; i < `FRAME_H; i++) begin
			line_sel[i] = ($urandom % 4) == 0;
		end
		line_sel[0] = 1'b1;
		line_sel[`FRAME_H-1] = 1'b1;
		repeat (10) begin
			@(negedge M10k_pll);
			check_idle();
		end
		reset = 1'b0;
		@(negedge M10k_pll);
		check_idle();
		running = 1'b1;
		wait (vsync_falls >= 3);
		@(negedge M10k_pll);
		if (quad_seen != 4'b1111) begin
			$display("Not every quadrant was reached by the pixel checks");
			$display("Done: errors found");
			$fatal(1, "quadrant coverage incomplete");
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Scan monitor sampling on the falling edge
	////////////////////////////////////////////////////////////

	always @(negedge M10k_pll) begin
		if (running) begin
			// Line period and sync pulse
			if (prev_hsync && !hsync) begin
				if (h_seen) begin
					check_count("hsync period", h_period, timing_pkg::coord_t'(line_len));
				end
				h_seen = 1'b1;
				h_period = '0;
				lines_in_frame = bump(lines_in_frame);
				if (!vsync) sync_lines = bump(sync_lines);
			end
			if (!prev_hsync && hsync) begin
				check_count("hsync pulse", h_low, timing_pkg::coord_t'(`H_PULSE));
				h_low = '0;
			end
			// Frame boundaries at vsync fall
			if (prev_vsync && !vsync) begin
				if (vsync_falls > 0) begin
					check_count("lines per frame", lines_in_frame,
						timing_pkg::coord_t'(frame_lines));
					check_count("active lines", active_lines, timing_pkg::coord_t'(`FRAME_H));
				end
				vsync_falls++;
				lines_in_frame = '0;
				active_lines = '0;
			end
			if (!prev_vsync && vsync) begin
				check_count("vsync lines", sync_lines, timing_pkg::coord_t'(`V_PULSE));
				sync_lines = '0;
			end
			// Active region edges
			if (!prev_blank && blank_n) begin
				px = 0;
				py = int'(active_lines);
				active_lines = bump(active_lines);
			end
			if (prev_blank && !blank_n) begin
				check_count("active cycles", blank_len, timing_pkg::coord_t'(`FRAME_W));
				blank_len = '0;
			end
			if (blank_n) begin
				blank_len = bump(blank_len);
				// Buffer is only trusted from the second frame
				if (vsync_falls > 0 && py < `FRAME_H && line_sel[py]) begin
					ref_color(px, py, exp_r, exp_g, exp_b);
					check_color("red", red, exp_r);
					check_color("green", green, exp_g);
					check_color("blue", blue, exp_b);
					quad_seen[quadrant(px, py)] = 1'b1;
				end
				px++;
			end else begin
				check_color("red in blanking", red, 8'h00);
				check_color("green in blanking", green, 8'h00);
				check_color("blue in blanking", blue, 8'h00);
			end
			if (!hsync) h_low = bump(h_low);
			h_period = bump(h_period);
			prev_hsync = hsync;
			prev_vsync = vsync;
			prev_blank = blank_n;
		end
	end

endmodule
